//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_i2s_top
FLIST     := i2s_loopback_top.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- i2s_loopback_top.f
+incdir+src
src/i2s_pkg.sv
src/i2s_sck_gen.sv
src/i2s_serializer.sv
src/i2s_deserializer.sv
src/i2s_loopback_top.sv
test/tb_i2s_clock.sv
test/tb_i2s_checker.sv
test/tb_i2s_top.sv

//--- src/i2s_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

`include "i2s_params.svh"

// I2S receiver for the loopback path
// Samples sd and ws on the serial clock rising edge
module i2s_deserializer (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          sck_rise,      // Sample strobe
    input  wire logic          i2so_sd,       // Serial data
    input  wire logic          i2so_ws,       // Word select, low = left
    output i2s_pkg::i2s_sample_t i2si_lft,    // Received left word
    output i2s_pkg::i2s_sample_t i2si_rgt,    // Received right word
    output logic               rx_valid       // One clk, new pair on the outputs
);

    import i2s_pkg::*;

    logic                     ws_d;           // ws at the previous sample
    logic                     ws_chg;         // This sample is an LSB
    logic                     seen_edge;      // A ws change seen since reset
    logic                     ovr;            // More bits than a word holds
    logic                     lft_ok;         // Complete left word waiting
    i2s_bit_idx_t             bit_cnt;        // Bits taken since the last ws change
    logic [`I2S_SAMPLE_W-1:0] sh;
    i2s_sample_t              word;           // Word closed by the current sample
    i2s_sample_t              lft_hold;
    logic                     rx_fire;

    assign ws_chg  = (i2so_ws != ws_d);
    assign word    = {sh[`I2S_SAMPLE_W-2:0], i2so_sd};
    assign rx_fire = sck_rise && ws_chg && ws_d && lft_ok;    // Right word done

    ////////////////////////////////////////////////////////////////////////////
    // Word framing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ws_d      <= 1'b0;
            seen_edge <= 1'b0;
            ovr       <= 1'b0;
            lft_ok    <= 1'b0;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
        end
        else
        begin
            rx_valid <= rx_fire;
            if (sck_rise)
            begin
                ws_d <= i2so_ws;
                if (ws_chg)
                begin
                    // Next sample is the MSB of the other channel
                    bit_cnt   <= '0;
                    ovr       <= 1'b0;
                    seen_edge <= 1'b1;
                    if (!ws_d)
                        lft_ok <= seen_edge && !ovr && (bit_cnt == bit_idx_msb);
                    else
                        lft_ok <= 1'b0;     // Pair delivered or dropped
                end
                else if (bit_cnt == bit_idx_msb)
                    ovr <= 1'b1;            // Idle line or a stretched word
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sample path
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (sck_rise)
        begin
            sh <= {sh[`I2S_SAMPLE_W-2:0], i2so_sd};     // MSB first
            if (ws_chg && !ws_d)
                lft_hold <= word;   // Left done, wait for right
        end
        if (rx_fire)
        begin
            i2si_lft <= lft_hold;
            i2si_rgt <= word;
        end
    end

    // A pair goes out only after a full right word since ws rose
    a_rgt_full : assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |-> $past(ws_d && !ovr && (bit_cnt == bit_idx_msb)));

endmodule

`default_nettype wire

//--- src/i2s_loopback_top.sv
`timescale 1ns/1ns
`default_nettype none

// I2S transmit path with a local receiver on the same serial lines
module i2s_loopback_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 rts,        // Ready to send
    input  wire i2s_pkg::i2s_sample_t lft,
    input  wire i2s_pkg::i2s_sample_t rgt,
    output logic                      rtr,        // Next pair wanted
    output logic                      i2so_sck,   // Serial lines, also looped back
    output logic                      i2so_sd,
    output logic                      i2so_ws,
    output logic                      i2so_en,
    output logic                      rx_valid,   // Looped pair ready
    output i2s_pkg::i2s_sample_t      i2si_lft,
    output i2s_pkg::i2s_sample_t      i2si_rgt
);

    logic sck_rise;     // Edge strobes from the divider
    logic sck_fall;

    i2s_sck_gen i_sck_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck      (i2so_sck),
        .sck_rise (sck_rise),
        .sck_fall (sck_fall)
    );

    i2s_serializer i_ser (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck_rise (sck_rise),
        .sck_fall (sck_fall),
        .rts      (rts),
        .lft      (lft),
        .rgt      (rgt),
        .i2so_sd  (i2so_sd),
        .i2so_ws  (i2so_ws),
        .i2so_en  (i2so_en),
        .rtr      (rtr)
    );

    // Receiver listens to the transmitter's own lines
    i2s_deserializer i_des (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck_rise (sck_rise),
        .i2so_sd  (i2so_sd),
        .i2so_ws  (i2so_ws),
        .i2si_lft (i2si_lft),
        .i2si_rgt (i2si_rgt),
        .rx_valid (rx_valid)
    );

endmodule

`default_nettype wire

//--- src/i2s_params.svh
`ifndef I2S_PARAMS_SVH
`define I2S_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// I2S link dimensions
////////////////////////////////////////////////////////////////////////////

// Bits per audio sample, one channel
`define I2S_SAMPLE_W 16

// clk cycles per half period of the serial clock
// Keep at 2 or more so the divider has a counter to run
`define I2S_SCK_DIV 4

// Serial clock periods in one stereo frame (left plus right)
`define I2S_FRAME_BITS (2 * `I2S_SAMPLE_W)

`endif

//--- src/i2s_pkg.sv
`default_nettype none

`include "i2s_params.svh"

////////////////////////////////////////////////////////////////////////////
// Types shared by the transmit path, the loopback receiver and the testbench
////////////////////////////////////////////////////////////////////////////

package i2s_pkg;

    // One signed PCM sample
    typedef logic signed [`I2S_SAMPLE_W-1:0] i2s_sample_t;

    // Position of a bit inside one sample word
    typedef logic [$clog2(`I2S_SAMPLE_W)-1:0] i2s_bit_idx_t;

    // Index of the MSB, first bit on the wire
    localparam i2s_bit_idx_t bit_idx_msb = i2s_bit_idx_t'(`I2S_SAMPLE_W - 1);

endpackage

`default_nettype wire

//--- src/i2s_sck_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "i2s_params.svh"

// Serial clock generator
// sck toggles every `I2S_SCK_DIV clk cycles, starting low out of reset
module i2s_sck_gen (
    input  wire logic clk,
    input  wire logic rst_n,
    output logic      sck,              // I2S serial clock, level
    output logic      sck_rise,         // One clk pulse, sck just went high
    output logic      sck_fall          // One clk pulse, sck just went low
);

    localparam int cnt_w = (`I2S_SCK_DIV > 2) ? $clog2(`I2S_SCK_DIV) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`I2S_SCK_DIV - 1);

    logic [cnt_w-1:0] div_cnt;          // Counts clk within a half period
    logic             div_wrap;         // Last cycle of the half period

    assign div_wrap = (div_cnt == cnt_last);

    // Strobes are registered next to sck
    // so a strobe and the new sck level show up in the same cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt  <= '0;
            sck      <= 1'b0;
            sck_rise <= 1'b0;
            sck_fall <= 1'b0;
        end
        else
        begin
            sck_rise <= div_wrap && !sck;   // Low now, high next
            sck_fall <= div_wrap && sck;    // High now, low next
            if (div_wrap)
            begin
                div_cnt <= '0;
                sck     <= !sck;
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    // Each strobe matches a real sck edge of its own direction
    // So the two are never high together and none is missed
    a_edge_strobe : assert property (@(posedge clk) disable iff (!rst_n)
        (sck_rise == $rose(sck)) && (sck_fall == $fell(sck)));

endmodule

`default_nettype wire

//--- src/i2s_serializer.sv
`timescale 1ns/1ns
`default_nettype none

`include "i2s_params.svh"

// I2S transmitter, Philips format, MSB first
// ws leads sd by one bit, both change on the serial clock falling edge
module i2s_serializer (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 sck_rise,   // Mid-bit strobe
    input  wire logic                 sck_fall,   // Bit boundary strobe
    input  wire logic                 rts,        // Ready to send, rising edge starts
    input  wire i2s_pkg::i2s_sample_t lft,        // Left sample from source
    input  wire i2s_pkg::i2s_sample_t rgt,        // Right sample from source
    output logic                      i2so_sd,    // Serial data
    output logic                      i2so_ws,    // Word select, low = left
    output logic                      i2so_en,    // High while streaming
    output logic                      rtr         // Pair taken, present the next one
);

    import i2s_pkg::*;

    logic                     rts_d;          // rts one clk ago
    logic                     rts_edge;
    logic                     rts_run;        // rts sampled mid-bit
    logic                     start_pend;     // Edge seen, wait for a falling edge
    logic                     active;
    logic                     last;           // Trailing LSB slot before idle
    logic                     lr;             // Channel that ws currently marks
    i2s_bit_idx_t             bit_cnt;        // Counts ws slots down to 0
    i2s_sample_t              lft_q;          // Pair captured at frame start
    i2s_sample_t              rgt_q;
    i2s_sample_t              cur_word;
    logic [`I2S_SAMPLE_W-1:0] sh;             // Remaining bits of the word on sd
    logic                     word_end;
    logic                     frame_start;
    logic                     first_bit;

    assign rts_edge    = rts && !rts_d;
    assign word_end    = sck_fall && active && !last && (bit_cnt == '0);
    assign frame_start = word_end && lr && rts_run;   // Right slot ends, source still on
    assign first_bit   = active && !last && (bit_cnt == bit_idx_msb);
    assign cur_word    = lr ? rgt_q : lft_q;
    assign rtr         = frame_start;
    assign i2so_en     = active;

    ////////////////////////////////////////////////////////////////////////////
    // Frame control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rts_d      <= 1'b0;
            rts_run    <= 1'b0;
            start_pend <= 1'b0;
            active     <= 1'b0;
            last       <= 1'b0;
            lr         <= 1'b0;
            bit_cnt    <= '0;
            i2so_ws    <= 1'b0;
        end
        else
        begin
            rts_d <= rts;
            if (sck_rise)
                rts_run <= rts;             // Stable well before the next boundary

            if (rts_edge)
                start_pend <= 1'b1;
            else if (frame_start || (sck_fall && !active))
                start_pend <= 1'b0;         // Consumed or stale

            if (sck_fall)
            begin
                if (!active)
                begin
                    // One dummy right slot so ws can fall ahead of the first left MSB
                    if (start_pend)
                    begin
                        active  <= 1'b1;
                        lr      <= 1'b1;
                        i2so_ws <= 1'b1;
                        bit_cnt <= '0;
                    end
                end
                else if (last)
                begin
                    active  <= 1'b0;        // Right LSB is out, go idle
                    last    <= 1'b0;
                    i2so_ws <= 1'b0;
                end
                else if (bit_cnt == '0)
                begin
                    lr      <= !lr;         // Word boundary, ws flips a bit early
                    i2so_ws <= !lr;
                    bit_cnt <= bit_idx_msb;
                    if (lr && !rts_run)
                        last <= 1'b1;       // Source stopped, finish this frame
                end
                else
                    bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (frame_start)
        begin
            lft_q <= lft;
            rgt_q <= rgt;
        end
    end

    // The shifter keeps the old right word alive across the capture
    always_ff @(posedge clk)
    begin
        if (sck_fall)
        begin
            if (!active)
                sh <= '0;                   // Dummy slot sends zero
            else if (first_bit)
                sh <= {cur_word[`I2S_SAMPLE_W-2:0], 1'b0};
            else
                sh <= sh << 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            i2so_sd <= 1'b0;
        else if (sck_fall)
        begin
            if (!active || last)
                i2so_sd <= 1'b0;
            else if (first_bit)
                i2so_sd <= cur_word[bit_idx_msb];   // MSB, one bit after ws
            else
                i2so_sd <= sh[bit_idx_msb];
        end
    end

    // Source sees exactly one strobe per frame
    a_rtr_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        rtr |=> !rtr);

    // ws moves only on a serial clock falling edge where a word or the stream starts
    a_ws_on_fall : assert property (@(posedge clk) disable iff (!rst_n)
        $changed(i2so_ws) |->
            $past(sck_fall) && ((bit_cnt == bit_idx_msb) || $rose(i2so_en)));

endmodule

`default_nettype wire

//--- test/i2s_testdata.txt
// One stereo pair per line in hex
// Column 1 left sample, column 2 right sample
1234 abcd
0000 0000
ffff ffff
8000 7fff
7fff 8000
aaaa 5555
5555 aaaa
0001 8001
fffe 0002
0f0f f0f0
00ff ff00
dead beef
cafe f00d
4c3b 2a19
9182 7364
0100 0080
c000 3fff
6a5b 4c3d
b1e2 d3f4
2468 1357

//--- test/tb_i2s_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "i2s_params.svh"

// Watches the DUT ports and compares serial framing and looped pairs
module tb_i2s_checker (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 rtr,
    input  wire logic                 i2so_sck,
    input  wire logic                 i2so_sd,
    input  wire logic                 i2so_ws,
    input  wire logic                 i2so_en,
    input  wire logic                 rx_valid,
    input  wire i2s_pkg::i2s_sample_t i2si_lft,
    input  wire i2s_pkg::i2s_sample_t i2si_rgt,
    input  wire logic                 exp_push,   // New expected pair from the source
    input  wire i2s_pkg::i2s_sample_t exp_lft,
    input  wire i2s_pkg::i2s_sample_t exp_rgt,
    input  wire logic                 end_check,  // Stimulus done, check totals
    output int                        errors
);

    import i2s_pkg::*;

    i2s_sample_t exp_l[$];          // Pairs in the order the source offered them
    i2s_sample_t exp_r[$];
    int          rx_idx = 0;        // Next pair expected on rx_valid
    int          ser_idx = 0;       // Next pair expected on the serial line
    int          rtr_cnt = 0;
    int          bit_cnt = 0;       // Samples since the last ws change
    int          sync_st = 0;       // 0 idle, 1 dummy slot, 2 locked to frames
    int          sck_len = 0;       // clk cycles at the current sck level, 0 before the first edge
    logic        sck_d = 1'b0;
    logic        ws_d = 1'b0;       // ws at the previous sck rise
    logic        en_d = 1'b0;
    logic        end_d = 1'b0;
    i2s_sample_t word = '0;         // Bits rebuilt from sd

    initial
    begin
        errors = 0;
    end

    task automatic value_check(input string sig, input i2s_sample_t got, input i2s_sample_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic fault(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Serial line decode, one call per sck rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic sample_bit();
        if (!i2so_en)
        begin
            sync_st = 0;                    // Relock on the next start
            ws_d    = i2so_ws;
        end
        else
        begin
            word = {word[`I2S_SAMPLE_W-2:0], i2so_sd};  // MSB first
            if (i2so_ws != ws_d)
            begin
                // This sample is the LSB of the word that just ended
                if (sync_st < 2)
                    sync_st++;              // Start edge, then the dummy slot
                else
                begin
                    if (bit_cnt + 1 != `I2S_SAMPLE_W)
                        fault("serial word has the wrong number of bits");
                    if (ser_idx >= exp_l.size())
                        fault("serial word sent with no pair queued");
                    else if (i2so_ws)
                    begin
                        value_check("i2so_sd left word", word, exp_l[ser_idx]);
                        if (rtr_cnt != ser_idx + 1)
                            fault("rtr count does not match the frame count");
                    end
                    else
                    begin
                        value_check("i2so_sd right word", word, exp_r[ser_idx]);
                        ser_idx++;
                    end
                end
                bit_cnt = 0;
            end
            else
            begin
                bit_cnt++;
                if (bit_cnt == `I2S_SAMPLE_W)
                    fault("word select held longer than one word");
            end
            ws_d = i2so_ws;
        end
    endtask

    always @(posedge clk)
    begin
        if (exp_push)
        begin
            exp_l.push_back(exp_lft);
            exp_r.push_back(exp_rgt);
        end
    end

    // Outputs move on posedge, so the falling edge sees them settled
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            if (rtr || rx_valid || i2so_en || i2so_ws || i2so_sd)
                fault("control output active during reset");
            sync_st = 0;
        end
        else
        begin
            if (!i2so_en && (i2so_ws || i2so_sd || rtr))
                fault("ws, sd or rtr high while the transmitter is idle");
            if (en_d && !i2so_en && (ser_idx != exp_l.size()))
                fault("stream stopped before the last queued frame went out");
            if (rtr)
            begin
                rtr_cnt++;
                if (i2so_sck || !sck_d || !i2so_ws)
                    fault("rtr not at the falling edge before the left MSB slot");
            end
            if (rx_valid)
            begin
                if (rx_idx >= exp_l.size())
                    fault("rx_valid with no pair expected");
                else
                begin
                    value_check("i2si_lft", i2si_lft, exp_l[rx_idx]);
                    value_check("i2si_rgt", i2si_rgt, exp_r[rx_idx]);
                end
                rx_idx++;
            end
            if (i2so_sck && !sck_d)
                sample_bit();
            // Serial clock half period, measured from the first edge on
            if (i2so_sck != sck_d)
            begin
                if (sck_len != 0 && sck_len != `I2S_SCK_DIV)
                begin
                    errors++;
                    $display("** Error at %0t ns: i2so_sck half period = %0d, expected %0d",
                             $time, sck_len, `I2S_SCK_DIV);
                end
                sck_len = 1;
            end
            else if (sck_len != 0)
                sck_len++;
            if (end_check && !end_d)
            begin
                // Totals once the stimulus has finished
                if (rx_idx != exp_l.size())
                    fault("rx_valid count differs from the number of pairs");
                if (rtr_cnt != exp_l.size())
                    fault("rtr count differs from the number of pairs");
                if (ser_idx != exp_l.size())
                    fault("not every pair appeared on the serial line");
            end
            sck_d = i2so_sck;
            en_d  = i2so_en;
            end_d = end_check;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_i2s_clock.sv
`timescale 1ns/1ns
`default_nettype none

// Free running testbench clock, 8 ns period
module tb_i2s_clock (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;   // Half period

endmodule

`default_nettype wire

//--- test/tb_i2s_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "i2s_params.svh"

module tb_i2s_top;

    import i2s_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        rts;
    logic        exp_push;
    logic        end_check;
    i2s_sample_t lft, rgt;
    i2s_sample_t exp_lft, exp_rgt;
    logic        rtr, i2so_sck, i2so_sd, i2so_ws, i2so_en, rx_valid;
    i2s_sample_t i2si_lft, i2si_rgt;
    i2s_sample_t pair_l[$];         // Pairs from the data file
    i2s_sample_t pair_r[$];
    int          errors;
    int          cycles = 0;
    int          limit = 1000000;   // Replaced once the file is read

    tb_i2s_clock i_clk (.clk(clk));

    i2s_loopback_top i_dut (
        .clk(clk), .rst_n(rst_n), .rts(rts), .lft(lft), .rgt(rgt),
        .rtr(rtr), .i2so_sck(i2so_sck), .i2so_sd(i2so_sd), .i2so_ws(i2so_ws),
        .i2so_en(i2so_en), .rx_valid(rx_valid), .i2si_lft(i2si_lft), .i2si_rgt(i2si_rgt)
    );

    tb_i2s_checker i_chk (
        .clk(clk), .rst_n(rst_n), .rtr(rtr), .i2so_sck(i2so_sck), .i2so_sd(i2so_sd),
        .i2so_ws(i2so_ws), .i2so_en(i2so_en), .rx_valid(rx_valid),
        .i2si_lft(i2si_lft), .i2si_rgt(i2si_rgt), .exp_push(exp_push),
        .exp_lft(exp_lft), .exp_rgt(exp_rgt), .end_check(end_check), .errors(errors)
    );

    // Watchdog
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display("Timeout after %0d clock cycles, the DUT stopped responding", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Put a pair on the source port and tell the checker; called on a falling edge
    task automatic present_pair(input i2s_sample_t l, input i2s_sample_t r);
        lft      = l;
        rgt      = r;
        exp_lft  = l;
        exp_rgt  = r;
        exp_push = 1'b1;
        @(negedge clk);
        exp_push = 1'b0;
    endtask

    task automatic wait_rtr();
        do @(negedge clk); while (!rtr);
    endtask

    task automatic wait_idle();
        do @(negedge clk); while (i2so_en);
    endtask

    task automatic load_pairs();
        int          fd;
        int          n;
        string       line;
        i2s_sample_t l, r;
        fd = $fopen("test/i2s_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open test/i2s_testdata.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0 && $sscanf(line, "%h %h", l, r) == 2)    // Comment lines give 0
                begin
                    pair_l.push_back(l);
                    pair_r.push_back(r);
                end
            end
            $fclose(fd);
        end
    endtask

    initial
    begin
        int seed;
        rst_n     = 1'b0;
        rts       = 1'b0;
        exp_push  = 1'b0;
        end_check = 1'b0;
        lft       = '0;
        rgt       = '0;
        exp_lft   = '0;
        exp_rgt   = '0;
        seed      = $urandom(32'hb56d7be8);
        load_pairs();
        // File frames plus the random one, with slack for start and stop
        limit = (pair_l.size() + 1 + 4) * `I2S_FRAME_BITS * 2 * `I2S_SCK_DIV;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        ////////////////////////////////////////////////////////////////////////
        // Stream the file, one pair per rtr
        ////////////////////////////////////////////////////////////////////////
        @(negedge clk);
        present_pair(pair_l[0], pair_r[0]);
        rts = 1'b1;
        for (int k = 1; k < pair_l.size(); k++)
        begin
            wait_rtr();
            @(negedge clk);             // Capture closes at the end of the rtr cycle
            present_pair(pair_l[k], pair_r[k]);
        end
        wait_rtr();
        @(negedge clk);
        rts = 1'b0;                     // Last frame still goes out
        wait_idle();

        // Restart with one random pair
        repeat (10) @(negedge clk);
        present_pair(i2s_sample_t'($urandom), i2s_sample_t'($urandom));
        rts = 1'b1;
        wait_rtr();
        @(negedge clk);
        rts = 1'b0;
        wait_idle();

        repeat (4) @(negedge clk);
        end_check = 1'b1;
        repeat (2) @(negedge clk);
        end_check = 1'b0;
        repeat (2) @(negedge clk);

        $display("Errors: %0d, pairs sent: %0d, seed state %0d", errors, pair_l.size() + 1, seed);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
